//--- source/udp_test_pkg.sv
`default_nettype none

package udp_test_pkg;

	// ----------------------------------------
	// Bus and field types
	// ----------------------------------------
	typedef logic [31:0] word_t;        // First wire byte in [31:24]
	typedef logic [1:0]  byte_en_t;     // 0 = 4 bytes, else byte count
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [63:0] pkt_num_t;

	typedef struct packed {
		word_t    data;
		byte_en_t be;
		logic     sop;
		logic     eop;
	} mac_tx_word_t;

	// Frame geometry
	localparam int PAYLOAD_BYTES = 24;  // Multiple of 4, at least 12
	localparam int HEADER_BYTES  = 42;  // Eth 14 + IP 20 + UDP 8
	localparam int HEADER_WORDS  = HEADER_BYTES / 4;
	localparam int PAYLOAD_WORDS = PAYLOAD_BYTES / 4;
	localparam int FRAME_WORDS   = (HEADER_BYTES + PAYLOAD_BYTES + 3) / 4;
	localparam int CARRY_BITS    = 8 * (HEADER_BYTES % 4);  // Header tail left over

	typedef logic [$clog2(FRAME_WORDS)-1:0] word_idx_t;
	typedef logic [CARRY_BITS-1:0]          carry_t;

	localparam byte_en_t BE_FULL = 2'd0;
	localparam byte_en_t LAST_BE = byte_en_t'((HEADER_BYTES + PAYLOAD_BYTES) % 4);

	// Send timer, short for simulation
	localparam int SEND_INTERVAL = 64;
	localparam int TIMER_W       = $clog2(SEND_INTERVAL + 1);
	typedef logic [TIMER_W-1:0] timer_t;

	// ----------------------------------------
	// Ethernet / IPv4 / UDP header fields
	// ----------------------------------------
	localparam mac_addr_t   MAC_DST_ADDR  = 48'hFF_FF_FF_FF_FF_FF;  // Broadcast
	localparam mac_addr_t   MAC_SRC_ADDR  = 48'h04_D4_C4_A5_A8_E1;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

	localparam logic [3:0]  IP_VERSION    = 4'h4;
	localparam logic [3:0]  IP_HEAD_LEN   = 4'h5;   // 5 x 32 bit, no options
	localparam logic [7:0]  IP_DSF        = 8'h00;
	localparam logic [15:0] IP_TOTAL_LEN  = 16'(20 + 8 + PAYLOAD_BYTES);
	localparam logic [15:0] IP_ID         = 16'h64D7;
	localparam logic [15:0] IP_FRAG       = 16'h0000;  // Flags and offset
	localparam logic [7:0]  IP_TTL        = 8'd128;
	localparam logic [7:0]  IP_PROT_UDP   = 8'h11;
	localparam logic [15:0] IP_CHECKSUM   = 16'h0000;  // Sent as zero
	localparam ip_addr_t    IP_SRC_ADDR   = 32'hA9_FE_CE_77;  // 169.254.206.119
	localparam ip_addr_t    IP_DST_ADDR   = 32'hA9_FE_CE_78;

	localparam udp_port_t   UDP_SRC_PORT  = 16'hF718;
	localparam udp_port_t   UDP_DST_PORT  = 16'h1389;  // 5001
	localparam logic [15:0] UDP_LEN       = 16'(8 + PAYLOAD_BYTES);
	localparam logic [15:0] UDP_CHECKSUM  = 16'h0000;

	// Payload pattern
	localparam word_t      TEST_WORD    = 32'h00_01_02_03;
	localparam logic [7:0] PAYLOAD_STEP = 8'd4;  // Per byte, per word

	// Whole header, byte 0 in the top bits
	localparam logic [8*HEADER_BYTES-1:0] FRAME_HEADER = {
		MAC_DST_ADDR, MAC_SRC_ADDR, ETH_TYPE_IPV4,
		IP_VERSION, IP_HEAD_LEN, IP_DSF, IP_TOTAL_LEN, IP_ID, IP_FRAG,
		IP_TTL, IP_PROT_UDP, IP_CHECKSUM, IP_SRC_ADDR, IP_DST_ADDR,
		UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN, UDP_CHECKSUM
	};

	// Full header words and the bytes that spill into the payload words
	localparam word_t [0:HEADER_WORDS-1] HEADER_WORD =
		FRAME_HEADER[8*HEADER_BYTES-1 -: 32*HEADER_WORDS];
	localparam carry_t HEADER_CARRY = FRAME_HEADER[CARRY_BITS-1:0];

endpackage

`default_nettype wire

//--- source/udp_payload_source.sv
`timescale 1ns/1ps
`default_nettype none

module udp_payload_source (
	input  wire                  pll_62_5m_clk,
	input  wire                  rst_n,
	input  wire                  payload_rd_i,   // Builder took current word
	input  wire                  frame_done_i,   // Eop word went into buffer
	output logic                 start_o,        // One pulse per frame
	output udp_test_pkg::word_t  payload_o
);
	import udp_test_pkg::*;

	timer_t   timer_q;
	logic     expired;
	logic     start_lock_q;   // Blocks a second start in one frame
	pkt_num_t pkt_num_q;
	logic [1:0] seq_q;        // 0 hi, 1 lo, 2 test word or ramp
	word_t    ramp;

	// ----------------------------------------
	// Send timer and start pulse
	// ----------------------------------------
	assign expired = (timer_q == '0);

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			timer_q <= timer_t'(SEND_INTERVAL);
		else if (frame_done_i)
			timer_q <= timer_t'(SEND_INTERVAL);   // Reload after each frame
		else if (!expired)
			timer_q <= timer_q - 1'b1;
	end

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			start_o <= 1'b0;
		else if (start_o)
			start_o <= 1'b0;                      // Single cycle
		else if (expired && !start_lock_q)
			start_o <= 1'b1;
	end

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			start_lock_q <= 1'b0;
		else if (frame_done_i)
			start_lock_q <= 1'b0;
		else if (expired)
			start_lock_q <= 1'b1;
	end

	// Packet number, bumped at end of frame
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			pkt_num_q <= '0;
		else if (frame_done_i)
			pkt_num_q <= pkt_num_q + 1'b1;
	end

	// ----------------------------------------
	// Payload word sequence
	// ----------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			seq_q <= 2'd0;
		else if (start_o || frame_done_i)
			seq_q <= 2'd0;                        // Rewind
		else if (payload_rd_i && seq_q != 2'd2)
			seq_q <= seq_q + 1'b1;                // Saturates on ramp
	end

	// Every byte of the last word plus the step
	always_comb
	begin
		for (int b = 0; b < 4; b++)
			ramp[8*b +: 8] = payload_o[8*b +: 8] + PAYLOAD_STEP;
	end

	always_ff @(posedge pll_62_5m_clk)
	begin
		if (start_o)
			payload_o <= pkt_num_q[63:32];          // First word, number high half
		else if (payload_rd_i)
		begin
			case (seq_q)
				2'd0:    payload_o <= pkt_num_q[31:0];
				2'd1:    payload_o <= TEST_WORD;
				default: payload_o <= ramp;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/udp_frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module udp_frame_builder (
	input  wire                          pll_62_5m_clk,
	input  wire                          rst_n,
	input  wire                          start_i,
	input  wire                          full_i,        // Buffer cannot take a word
	input  wire udp_test_pkg::word_t     payload_i,
	output logic                         payload_rd_o,
	output logic                         word_wr_o,
	output logic                         frame_done_o,
	output udp_test_pkg::mac_tx_word_t   word_o
);
	import udp_test_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		PAYLOAD,
		TAIL
	} state_t;

	state_t    state_q;
	word_idx_t word_cnt_q;   // Word index inside frame
	carry_t    carry_q;      // Bytes waiting for the next word
	logic      last_hdr;
	logic      last_pld;

	assign last_hdr = (word_cnt_q == word_idx_t'(HEADER_WORDS - 1));
	assign last_pld = (word_cnt_q == word_idx_t'(HEADER_WORDS + PAYLOAD_WORDS - 1));

	// One word per cycle unless the buffer is full
	assign word_wr_o    = (state_q != IDLE) && !full_i;
	assign payload_rd_o = (state_q == PAYLOAD) && !full_i;
	assign frame_done_o = (state_q == TAIL) && !full_i;   // Eop write

	// ----------------------------------------
	// FSM and word counter
	// ----------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q    <= IDLE;
			word_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					word_cnt_q <= '0;
					if (start_i)
						state_q <= HEADER;
				end
				HEADER:
				begin
					if (word_wr_o)
					begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (last_hdr)
							state_q <= PAYLOAD;   // Header tail goes to carry
					end
				end
				PAYLOAD:
				begin
					if (word_wr_o)
					begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (last_pld)
							state_q <= TAIL;
					end
				end
				TAIL:
				begin
					if (word_wr_o)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Carry starts as the header's last bytes, then the payload low half
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (state_q == IDLE && start_i)
			carry_q <= HEADER_CARRY;
		else if (payload_rd_o)
			carry_q <= payload_i[CARRY_BITS-1:0];
	end

	// ----------------------------------------
	// Word assembly
	// ----------------------------------------
	always_comb
	begin
		word_o    = '0;
		word_o.be = BE_FULL;
		case (state_q)
			HEADER:
			begin
				word_o.data = HEADER_WORD[word_cnt_q[$clog2(HEADER_WORDS)-1:0]];
				word_o.sop  = (word_cnt_q == '0);   // Frame start
			end
			PAYLOAD:
				word_o.data = {carry_q, payload_i[31:CARRY_BITS]};
			TAIL:
			begin
				word_o.data = {carry_q, {(32-CARRY_BITS){1'b0}}};  // Pad after last bytes
				word_o.be   = LAST_BE;
				word_o.eop  = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/mac_tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx_buffer #(
	parameter int DEPTH = 8   // Power of two
) (
	input  wire                          pll_62_5m_clk,
	input  wire                          rst_n,
	input  wire                          word_wr_i,
	input  wire                          tx_wa_i,      // MAC write allowed
	input  wire udp_test_pkg::mac_tx_word_t word_i,
	output logic                         full_o,
	output logic                         tx_wr_o,      // One word per high cycle
	output udp_test_pkg::mac_tx_word_t   tx_word_o
);
	import udp_test_pkg::*;

	localparam int AW = $clog2(DEPTH);

	mac_tx_word_t  mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0]   count_q;
	logic          wr_en_q;     // Registered write-allowed
	logic          empty;
	logic          push;
	logic          pop;
	mac_tx_word_t  head;

	assign empty  = (count_q == '0);
	assign full_o = (count_q == (AW+1)'(DEPTH));
	assign push   = word_wr_i && !full_o;
	assign pop    = tx_wr_o;

	// ----------------------------------------
	// Word storage
	// ----------------------------------------
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (push)
			mem[wr_ptr_q] <= word_i;
	end

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at DEPTH
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;                        // Both or none
			endcase
		end
	end

	// ----------------------------------------
	// MAC side
	// ----------------------------------------
	// Write-allowed lags one cycle, so one extra word may follow a drop
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			wr_en_q <= 1'b0;
		else
			wr_en_q <= tx_wa_i;
	end

	assign tx_wr_o = wr_en_q && !empty;
	assign head    = mem[rd_ptr_q];

	// Frame markers only valid with a write
	always_comb
	begin
		tx_word_o     = head;
		tx_word_o.sop = head.sop && tx_wr_o;
		tx_word_o.eop = head.eop && tx_wr_o;
	end

endmodule

`default_nettype wire

//--- source/udp_test_sender.sv
`timescale 1ns/1ps
`default_nettype none

module udp_test_sender (
	input  wire                          pll_62_5m_clk,
	input  wire                          rst_n,
	input  wire                          tx_wa_i,     // From MAC user port
	output logic                         tx_wr_o,
	output udp_test_pkg::mac_tx_word_t   tx_word_o
);
	import udp_test_pkg::*;

	logic         start;
	word_t        payload;
	logic         payload_rd;
	logic         frame_done;
	mac_tx_word_t build_word;
	logic         build_wr;
	logic         buf_full;

	// Timer, packet number, payload words
	udp_payload_source u_source (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.payload_rd_i  (payload_rd),
		.frame_done_i  (frame_done),
		.start_o       (start),
		.payload_o     (payload)
	);

	// Headers plus payload into MAC words
	udp_frame_builder u_builder (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.start_i       (start),
		.full_i        (buf_full),
		.payload_i     (payload),
		.payload_rd_o  (payload_rd),
		.word_wr_o     (build_wr),
		.frame_done_o  (frame_done),
		.word_o        (build_word)
	);

	// Decouples builder from MAC back-pressure
	mac_tx_buffer #(
		.DEPTH (8)
	) u_buffer (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.word_wr_i     (build_wr),
		.tx_wa_i       (tx_wa_i),
		.word_i        (build_word),
		.full_o        (buf_full),
		.tx_wr_o       (tx_wr_o),
		.tx_word_o     (tx_word_o)
	);

endmodule

`default_nettype wire

//--- dv/udp_test_sender_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module udp_test_sender_assertions (
	input wire                             pll_62_5m_clk,
	input wire                             rst_n,
	input wire                             tx_wa_i,
	input wire                             tx_wr_o,
	input wire udp_test_pkg::mac_tx_word_t tx_word_o
);

	// ----------------------------------------
	// MAC user port protocol
	// ----------------------------------------
	reset_quiet: assert property (@(posedge pll_62_5m_clk) !rst_n |-> !tx_wr_o)
		else $error("tx_wr_o high during reset");

	// Frame markers never without a write
	markers_with_write: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		(tx_word_o.sop || tx_word_o.eop) |-> tx_wr_o)
		else $error("sop or eop without tx_wr_o");

	// One word of slack after write-allowed drops
	stop_after_drop: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		!tx_wa_i |=> !tx_wr_o)
		else $error("tx_wr_o still high two cycles after tx_wa_i fell");

endmodule

bind mac_tx_buffer udp_test_sender_assertions u_protocol_checks (
	.pll_62_5m_clk (pll_62_5m_clk),
	.rst_n         (rst_n),
	.tx_wa_i       (tx_wa_i),
	.tx_wr_o       (tx_wr_o),
	.tx_word_o     (tx_word_o)
);

`default_nettype wire

//--- dv/udp_test_sender_tb.sv
`timescale 1ns/1ps
`default_nettype none

module udp_test_sender_tb;
	import udp_test_pkg::*;

	localparam int CLK_PERIOD    = 200;
	localparam int RESET_CYCLES  = 3;
	localparam int NUM_FRAMES    = 4;
	localparam int MAX_CYCLES    = 2000;  // About 5x of 4 x (SEND_INTERVAL + 2 x FRAME_WORDS)
	localparam int STALL_AT_WORD = 5;     // Frame 3 stalls here
	localparam int STALL_CYCLES  = 40;

	logic         pll_62_5m_clk = 1'b0;
	logic         rst_n;
	logic         tx_wa_i;
	logic         tx_wr_o;
	mac_tx_word_t tx_word_o;

	int   cycle_cnt      = 0;
	int   first_wr_cycle = -1;   // Cycle of first MAC write
	int   word_idx       = 0;    // Word inside current frame
	int   frames_seen    = 0;
	int   checks         = 0;
	int   errors         = 0;
	int   mark_errs      = 0;    // Errors in be, sop or eop
	int   num_errs       = 0;    // Packet number field
	int   stall_writes   = 0;
	int   frame_errs [NUM_FRAMES];
	logic holding        = 1'b0;  // Write-allowed held low
	logic [7:0] rx_bytes [4*FRAME_WORDS];

	udp_test_sender dut (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.tx_wa_i       (tx_wa_i),
		.tx_wr_o       (tx_wr_o),
		.tx_word_o     (tx_word_o)
	);

	initial
	begin
		forever #(CLK_PERIOD/2) pll_62_5m_clk = ~pll_62_5m_clk;
	end

	// ----------------------------------------
	// Reference frame
	// ----------------------------------------
	// Byte pos of the frame on the wire for packet number num
	function automatic logic [7:0] frame_byte(input pkt_num_t num, input int pos);
		logic [8*HEADER_BYTES-1:0] hdr;
		word_t      pld_word;
		logic [7:0] val;
		int         pw;
		int         pb;
		hdr = {MAC_DST_ADDR, MAC_SRC_ADDR, ETH_TYPE_IPV4,
			IP_VERSION, IP_HEAD_LEN, 8'h00, IP_TOTAL_LEN, IP_ID, 16'h0000,
			IP_TTL, IP_PROT_UDP, 16'h0000, IP_SRC_ADDR, IP_DST_ADDR,
			UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN, 16'h0000};   // Checksums zero
		if (pos < HEADER_BYTES)
			return hdr[8*(HEADER_BYTES-1-pos) +: 8];
		if (pos >= HEADER_BYTES + PAYLOAD_BYTES)
			return 8'h00;                                     // Tail padding
		pw = (pos - HEADER_BYTES) / 4;
		pb = (pos - HEADER_BYTES) % 4;
		if (pw == 0)
			pld_word = num[63:32];
		else if (pw == 1)
			pld_word = num[31:0];
		else
			pld_word = TEST_WORD;
		val = pld_word[8*(3-pb) +: 8];
		if (pw > 2)
			val = val + 8'(int'(PAYLOAD_STEP) * (pw - 2));    // Ramp per word
		return val;
	endfunction

	function automatic mac_tx_word_t ref_word(input pkt_num_t num, input int idx);
		mac_tx_word_t w;
		w.data = {frame_byte(num, 4*idx), frame_byte(num, 4*idx + 1),
			frame_byte(num, 4*idx + 2), frame_byte(num, 4*idx + 3)};
		// Code is the valid byte count in the last word, with 4 as 0
		w.be   = (idx == FRAME_WORDS - 1) ?
			byte_en_t'(HEADER_BYTES + PAYLOAD_BYTES - 4*(FRAME_WORDS - 1)) : byte_en_t'(0);
		w.sop  = (idx == 0);
		w.eop  = (idx == FRAME_WORDS - 1);
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual, output bit bad);
		checks++;
		bad = 1'b0;
		assert (actual === expected)
		else
		begin
			$display("FAIL time %0t %s expected %h got %h", $time, name, expected, actual);
			errors++;
			bad = 1'b1;
		end
	endtask

	task automatic report_test(input string name, input int fails);
		if (fails == 0)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, fails);
	endtask

	// Drive write-allowed each falling edge until target frames are in
	task automatic drive_until_frames(input int target, input bit random_wa);
		while (frames_seen < target)
		begin
			@(negedge pll_62_5m_clk);
			tx_wa_i = random_wa ? 1'($urandom) : 1'b1;
		end
	endtask

	// ----------------------------------------
	// Comparator checks one MAC word per tx_wr_o
	// ----------------------------------------
	always @(posedge pll_62_5m_clk)
	begin
		if (rst_n && tx_wr_o)
		begin : compare
			mac_tx_word_t exp_w;
			pkt_num_t     rx_num;
			bit           bad_data;
			bit           bad_be;
			bit           bad_sop;
			bit           bad_eop;
			bit           bad_hi;
			bit           bad_lo;
			exp_w = ref_word(pkt_num_t'(frames_seen), word_idx);
			if (first_wr_cycle < 0)
				first_wr_cycle = cycle_cnt;
			if (holding)
				stall_writes++;
			check_value("tx_word_o.data", exp_w.data, tx_word_o.data, bad_data);
			check_value("tx_word_o.be", 32'(exp_w.be), 32'(tx_word_o.be), bad_be);
			check_value("tx_word_o.sop", 32'(exp_w.sop), 32'(tx_word_o.sop), bad_sop);
			check_value("tx_word_o.eop", 32'(exp_w.eop), 32'(tx_word_o.eop), bad_eop);
			if (bad_be || bad_sop || bad_eop)
				mark_errs++;
			if ((bad_data || bad_be || bad_sop || bad_eop) && frames_seen < NUM_FRAMES)
				frame_errs[frames_seen]++;
			for (int b = 0; b < 4; b++)
				rx_bytes[4*word_idx + b] = tx_word_o.data[8*(3-b) +: 8];
			if (word_idx == FRAME_WORDS - 1)
			begin
				rx_num = '0;
				for (int k = 0; k < 8; k++)
					rx_num = {rx_num[55:0], rx_bytes[HEADER_BYTES + k]};   // Big endian
				check_value("packet number high", 32'(frames_seen >>> 32), rx_num[63:32], bad_hi);
				check_value("packet number low", 32'(frames_seen), rx_num[31:0], bad_lo);
				if (bad_hi || bad_lo)
					num_errs++;
				$display("Frame %0d received, %0d words", frames_seen, FRAME_WORDS);
				frames_seen++;
				word_idx = 0;
			end
			else
				word_idx++;
		end
	end

	// Watchdog
	always @(negedge pll_62_5m_clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles with %0d frames received", cycle_cnt, frames_seen);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		bit early;
		void'($urandom(32'he70e));
		for (int f = 0; f < NUM_FRAMES; f++)
			frame_errs[f] = 0;
		rst_n   = 1'b0;
		tx_wa_i = 1'b0;
		early   = 1'b0;
		repeat (RESET_CYCLES) @(negedge pll_62_5m_clk);
		rst_n = 1'b1;

		drive_until_frames(1, 1'b0);   // Frame 0 with the MAC always ready
		checks++;
		assert (first_wr_cycle >= SEND_INTERVAL)
		else
		begin
			$display("tx_wr_o went high at cycle %0d, before the first frame was due",
				first_wr_cycle);
			errors++;
			early = 1'b1;
		end
		report_test("first frame after reset", frame_errs[0] + int'(early));

		drive_until_frames(3, 1'b1);   // Frames 1 and 2 under random back-pressure
		report_test("random back-pressure", frame_errs[1] + frame_errs[2]);

		// Frame 3 loses write-allowed mid frame
		while (word_idx < STALL_AT_WORD)
		begin
			@(negedge pll_62_5m_clk);
			tx_wa_i = 1'b1;
		end
		@(negedge pll_62_5m_clk);
		tx_wa_i = 1'b0;
		holding = 1'b1;
		repeat (STALL_CYCLES) @(negedge pll_62_5m_clk);
		holding = 1'b0;
		drive_until_frames(4, 1'b0);
		checks++;
		assert (stall_writes <= 1)
		else
		begin
			$display("%0d words written while write-allowed was low, at most 1 allowed",
				stall_writes);
			errors++;
		end
		report_test("write-allowed held low", frame_errs[3] + int'(stall_writes > 1));
		report_test("frame markers", mark_errs);
		report_test("packet numbers", num_errs);

		$display("Done: %0d frames, %0d checks, %0d errors", frames_seen, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
source/udp_test_pkg.sv
source/udp_payload_source.sv
source/udp_frame_builder.sv
source/mac_tx_buffer.sv
source/udp_test_sender.sv
dv/udp_test_sender_assertions.sv
dv/udp_test_sender_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module udp_test_sender_tb \
	-f project.f -Mdir obj_dir -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
